//--- build.f
+incdir+common
common/rotator_pkg.sv
common/bank_write_if.sv
common/bank_read_if.sv
rtl/header_decoder.sv
rtl/bank/weight_bank.sv
rtl/bank/pingpong_ctrl.sv
rtl/rotation_counter.sv
rtl/weight_rotator.sv
test/tb_clock_gen.sv
test/weight_rotator_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the weight rotator testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module weight_rotator_tb -f build.f \
  > build.log 2>&1 &&
./obj_dir/Vweight_rotator_tb > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log &&
{ echo "Simulation failed"; exit 1; } ||
echo "Simulation passed"

//--- test/weight_rotator_tb.sv
//----------------------------------------------------------
// Testbench for the weight rotator
// Sends a table of packets back to back and checks every
// output beat against a model of the cyclic playback
//----------------------------------------------------------
`timescale 1ns/1ns
`include "rotator_params.svh"

module weight_rotator_tb;

  localparam int BW      = `BEAT_BITS;
  localparam int N_PKT   = 6;
  localparam int MAX_LEN = 56;     // Largest kern_len in the table
  localparam int TIMEOUT = 50000;  // Cycles per wait

  logic                   aclk;
  logic                   aresetn;
  logic                   s_valid;
  logic                   s_ready;
  logic [BW-1:0]          s_data;
  logic                   s_last;
  logic                   m_ready;
  logic                   m_valid;
  logic [BW-1:0]          m_data;
  logic                   m_last;
  rotator_pkg::rot_user_t m_user;

  // Each row is kw2, cin_1, cols_1, blocks_1, xn_1 and the ready drop percent
  int pkt_tab [N_PKT][6] = '{
    '{1, 2, 3, 1, 0, 0},
    '{0, 0, 1, 0, 1, 30},
    '{3, 7, 0, 0, 0, 50},
    '{2, 3, 2, 1, 1, 20},
    '{1, 1, 15, 3, 3, 10},
    '{0, 4, 2, 0, 0, 60}
  };

  logic [BW-1:0]          weights [N_PKT][MAX_LEN];
  integer                 seed;
  int unsigned            rnd;
  int                     sent_q [$];  // Packet order at header acceptance
  int                     rx_done;
  int                     cur_drop;
  int                     overlaps;
  int                     header_waits;
  int                     mismatches;
  int                     other_errs;
  logic                   stalled;
  logic [BW-1:0]          held_data;
  rotator_pkg::rot_user_t held_user;
  logic                   held_last;

  tb_clock_gen u_clk (.o_aclk(aclk), .o_aresetn(aresetn));

  weight_rotator dut_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .i_s_valid (s_valid),
    .o_s_ready (s_ready),
    .i_s_data  (s_data),
    .i_s_last  (s_last),
    .i_m_ready (m_ready),
    .o_m_valid (m_valid),
    .o_m_data  (m_data),
    .o_m_last  (m_last),
    .o_m_user  (m_user)
  );

  function automatic int kern_len(input int p);
    return (2 * pkt_tab[p][0] + 1) * (pkt_tab[p][1] + 1);
  endfunction

  function automatic int total_beats(input int p);
    return kern_len(p) * (pkt_tab[p][2] + 1) * (pkt_tab[p][3] + 1) * (pkt_tab[p][4] + 1);
  endfunction

  function automatic logic [BW-1:0] header_word(input int p);
    rotator_pkg::rot_config_t h;
    h.kw2      = pkt_tab[p][0];
    h.cin_1    = pkt_tab[p][1];
    h.cols_1   = pkt_tab[p][2];
    h.blocks_1 = pkt_tab[p][3];
    h.xn_1     = pkt_tab[p][4];
    return BW'(h);  // Upper beat bits zero
  endfunction

  task automatic abort_on_timeout(input string what);
    other_errs++;
    $display("ERROR at %0t: timed out %s", $time, what);
    $display("Errors: %0d mismatches, %0d other", mismatches, other_errs);
    $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic check_value(input string what, input logic [BW-1:0] got,
                             input logic [BW-1:0] exp, input int p, input int n);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: pkt %0d beat %0d %s got %h expected %h",
               $time, p, n, what, got, exp);
    end
  endtask

  // Called once per cycle at the falling edge
  task automatic check_stall();
    if (stalled && (!m_valid || m_data !== held_data || m_user !== held_user ||
                    m_last !== held_last)) begin
      mismatches++;
      $display("MISMATCH at %0t: output changed while stalled", $time);
    end
    stalled   = m_valid && !m_ready;
    held_data = m_data;
    held_user = m_user;
    held_last = m_last;
  endtask

  task automatic send_beat(input logic [BW-1:0] data, input logic last);
    int waited;
    waited  = 0;
    s_valid = 1'b1;
    s_data  = data;
    s_last  = last;
    @(negedge aclk);
    while (!s_ready && waited < TIMEOUT) begin
      waited++;
      @(negedge aclk);
    end
    if (!s_ready) abort_on_timeout("waiting for o_s_ready");
    @(posedge aclk);
    #1;
  endtask

  task automatic send_packet(input int p);
    logic bank_busy;
    bank_busy = (p >= 2) && (rx_done < p - 1);  // Both banks hold packets not yet played
    send_beat(header_word(p), 1'b0);
    sent_q.push_back(p);
    if (bank_busy) header_waits++;
    if (p >= 2 && rx_done < p - 1) begin
      other_errs++;
      $display("ERROR at %0t: header of packet %0d accepted before a bank was free",
               $time, p);
    end
    for (int n = 0; n < kern_len(p); n++) begin
      send_beat(weights[p][n], n == kern_len(p) - 1);
    end
    if (p > 0 && rx_done < p) overlaps++;  // Earlier packet still playing back
  endtask

  task automatic wait_out_beat(input string what);
    int cnt;
    cnt = 0;
    @(negedge aclk);
    check_stall();
    while (!(m_valid && m_ready) && cnt < TIMEOUT) begin
      cnt++;
      @(negedge aclk);
      check_stall();
    end
    if (!(m_valid && m_ready)) abort_on_timeout(what);
  endtask

  task automatic monitor_output();
    int p;
    int len;
    int pos;
    int col;
    for (int k = 0; k < N_PKT; k++) begin
      cur_drop = pkt_tab[k][5];
      wait_out_beat("waiting for a header beat");
      p = k;
      if (sent_q.size() == 0) begin
        other_errs++;
        $display("ERROR at %0t: header beat arrived before its packet was sent", $time);
      end else begin
        p = sent_q.pop_front();
      end
      len = kern_len(p);
      check_value("header data", m_data, header_word(p), p, 0);
      check_value("header is_config", BW'(m_user.is_config), BW'(1), p, 0);
      check_value("header kw2", BW'(m_user.kw2), BW'(pkt_tab[p][0]), p, 0);
      check_value("header last", BW'(m_last), '0, p, 0);
      for (int n = 0; n < total_beats(p); n++) begin
        wait_out_beat("waiting for a weight beat");
        pos = n % len;
        col = (n / len) % (pkt_tab[p][2] + 1);
        check_value("data", m_data, weights[p][pos], p, n);
        check_value("is_config", BW'(m_user.is_config), '0, p, n);
        check_value("kw2", BW'(m_user.kw2), BW'(pkt_tab[p][0]), p, n);
        check_value("is_w_first_clk", BW'(m_user.is_w_first_clk), BW'(pos == 0), p, n);
        check_value("is_cin_last", BW'(m_user.is_cin_last), BW'(pos == len - 1), p, n);
        check_value("is_w_last", BW'(m_user.is_w_last), BW'(col == pkt_tab[p][2]), p, n);
        check_value("last", BW'(m_last), BW'(n == total_beats(p) - 1), p, n);
      end
      rx_done++;
    end
  endtask

  // Output back-pressure redrawn every cycle
  initial begin
    m_ready = 1'b0;
    forever begin
      @(posedge aclk);
      #1;
      rnd     = $random(seed);
      m_ready = (rnd % 100) >= cur_drop;
    end
  end

  initial begin
    int cnt;
    int extra;
    s_valid      = 1'b0;
    s_data       = '0;
    s_last       = 1'b0;
    seed         = 32'h0aad_f3e2;
    rx_done      = 0;
    cur_drop     = 0;
    overlaps     = 0;
    header_waits = 0;
    mismatches   = 0;
    other_errs   = 0;
    stalled      = 1'b0;
    extra        = 0;
    for (int p = 0; p < N_PKT; p++) begin
      for (int n = 0; n < MAX_LEN; n++) weights[p][n] = $random(seed);
    end
    cnt = 0;
    while (aresetn !== 1'b1 && cnt < 100) begin
      cnt++;
      @(posedge aclk);
    end
    if (aresetn !== 1'b1) abort_on_timeout("waiting for reset release");
    #1;
    fork
      begin
        for (int p = 0; p < N_PKT; p++) send_packet(p);
        s_valid = 1'b0;
      end
      monitor_output();
    join
    repeat (20) begin
      @(negedge aclk);
      if (m_valid) extra++;
    end
    if (extra > 0) begin
      other_errs++;
      $display("ERROR: output beats appeared after the last packet ended");
    end
    if (overlaps == 0) begin
      other_errs++;
      $display("ERROR: no packet was accepted while an earlier one was playing back");
    end
    if (header_waits == 0) begin
      other_errs++;
      $display("ERROR: no header ever had to wait for a free bank");
    end
    $display("Errors: %0d mismatches, %0d other", mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- test/tb_clock_gen.sv
//----------------------------------------------------------
// Clock and reset source for the weight rotator testbench
// Reset is released 1 ns after a rising edge
//----------------------------------------------------------
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 10
) (
  output logic o_aclk,
  output logic o_aresetn
);

  initial begin
    o_aclk = 1'b0;
    forever #(PERIOD_NS / 2) o_aclk = ~o_aclk;
  end

  initial begin
    o_aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_aclk);
    #1 o_aresetn = 1'b1;
  end

endmodule

//--- rtl/weight_rotator.sv
//----------------------------------------------------------
// Weight rotation buffer top level with plain stream ports
// Input packets are header plus weights, output is cyclic
//----------------------------------------------------------
`timescale 1ns/1ns
`include "rotator_params.svh"

module weight_rotator (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  logic                   i_s_valid,
  output logic                   o_s_ready,
  input  logic [`BEAT_BITS-1:0]  i_s_data,
  input  logic                   i_s_last,
  input  logic                   i_m_ready,
  output logic                   o_m_valid,
  output logic [`BEAT_BITS-1:0]  o_m_data,
  output logic                   o_m_last,
  output rotator_pkg::rot_user_t o_m_user
);

  bank_write_if wr_bus ();
  bank_read_if  rd_bus ();

  header_decoder u_decode (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_data  (i_s_data),
    .i_s_last  (i_s_last),
    .wr        (wr_bus.decoder)
  );

  // Two banks, fill one while the other plays back
  pingpong_ctrl u_execute (
    .aclk    (aclk),
    .aresetn (aresetn),
    .wr      (wr_bus.ctrl),
    .rd      (rd_bus.ctrl)
  );

  rotation_counter u_result (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .rd        (rd_bus.counter),
    .i_m_ready (i_m_ready),
    .o_m_valid (o_m_valid),
    .o_m_data  (o_m_data),
    .o_m_last  (o_m_last),
    .o_m_user  (o_m_user)
  );

endmodule

//--- rtl/rotation_counter.sv
//----------------------------------------------------------
// Plays the stored kernel out as a beat stream, header beat
// first, then weights with position flags in tuser
//----------------------------------------------------------
`timescale 1ns/1ns
`include "rotator_params.svh"

module rotation_counter (
  input  logic                   aclk,
  input  logic                   aresetn,
  bank_read_if.counter           rd,
  input  logic                   i_m_ready,
  output logic                   o_m_valid,
  output logic [`BEAT_BITS-1:0]  o_m_data,
  output logic                   o_m_last,
  output rotator_pkg::rot_user_t o_m_user
);

  localparam int BW = `BEAT_BITS;

  typedef enum logic {C_HDR, C_WTS} cnt_state_t;

  cnt_state_t                     state;
  rotator_pkg::rot_config_t       cfg;
  logic [rotator_pkg::BITS_KW-1:0]  c_kw;
  logic [rotator_pkg::BITS_CI-1:0]  c_cin;
  logic [rotator_pkg::BITS_XW-1:0]  c_cols;
  logic [rotator_pkg::BITS_BLK-1:0] c_blocks;
  logic [rotator_pkg::BITS_XN-1:0]  c_xn;
  logic l_kw, l_cin, l_cols, l_blocks, l_xn, l_all;
  logic weights;
  logic en;

  assign cfg      = rd.cfg.cfg;
  assign weights  = (state == C_WTS);
  assign l_kw     = (c_kw == {cfg.kw2, 1'b0});
  assign l_cin    = (c_cin == cfg.cin_1);
  assign l_cols   = (c_cols == cfg.cols_1);
  assign l_blocks = (c_blocks == cfg.blocks_1);
  assign l_xn     = (c_xn == cfg.xn_1);
  assign l_all    = l_kw && l_cin && l_cols && l_blocks && l_xn;

  assign o_m_valid   = rd.rd_valid;          // Header waits for the first weight
  assign rd.rd_ready = weights && i_m_ready;
  assign en          = weights && rd.rd_valid && i_m_ready;
  assign rd.rd_done  = en && l_all;

  always_ff @(posedge aclk) begin
    if (!aresetn) state <= C_HDR;
    else if (!weights && o_m_valid && i_m_ready) state <= C_WTS;
    else if (rd.rd_done) state <= C_HDR;
  end

  // kw innermost, then cin, cols, blocks, xn
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      c_kw     <= '0;
      c_cin    <= '0;
      c_cols   <= '0;
      c_blocks <= '0;
      c_xn     <= '0;
    end else if (en) begin
      c_kw <= l_kw ? '0 : c_kw + 1'b1;
      if (l_kw) begin
        c_cin <= l_cin ? '0 : c_cin + 1'b1;
        if (l_cin) begin
          c_cols <= l_cols ? '0 : c_cols + 1'b1;
          if (l_cols) begin
            c_blocks <= l_blocks ? '0 : c_blocks + 1'b1;
            if (l_blocks) c_xn <= l_xn ? '0 : c_xn + 1'b1;
          end
        end
      end
    end
  end

  assign o_m_data = weights ? rd.rd_data : BW'(cfg); // Header zero extended
  assign o_m_last = weights && l_all;

  assign o_m_user.is_config      = !weights;
  assign o_m_user.kw2            = cfg.kw2;
  assign o_m_user.is_w_first_clk = weights && (c_kw == '0) && (c_cin == '0);
  assign o_m_user.is_cin_last    = weights && l_kw && l_cin;
  assign o_m_user.is_w_last      = weights && l_cols;

endmodule

//--- rtl/bank/pingpong_ctrl.sv
//----------------------------------------------------------
// Ping-pong bank controller, one bank fills while the other
// is played back, with a two entry skid on the read side
//----------------------------------------------------------
`timescale 1ns/1ns
`include "rotator_params.svh"

module pingpong_ctrl (
  input  logic       aclk,
  input  logic       aresetn,
  bank_write_if.ctrl wr,
  bank_read_if.ctrl  rd
);

  typedef enum logic [1:0] {W_IDLE, W_GET_HDR, W_WRITE, W_SWITCH} wr_state_t;
  typedef enum logic [1:0] {R_IDLE, R_READ, R_SWITCH} rd_state_t;

  wr_state_t                  w_state;
  rd_state_t                  r_state;
  logic                       w_idx;
  logic                       r_idx;
  logic [1:0]                 done_write;
  logic [1:0]                 done_read;
  rotator_pkg::rot_bank_cfg_t hdr_reg [2];
  logic                       wq_valid;
  logic [`BEAT_BITS-1:0]      wq_data;
  logic [1:0]                 bank_clear;
  logic [1:0]                 bank_wen;
  logic [1:0]                 bank_ren;
  logic [`BEAT_BITS-1:0]      bank_rdata [2];
  logic                       hdr_take;
  logic                       ren;
  logic                       pend;
  logic                       pop;
  logic [1:0]                 occ;
  logic [1:0]                 skid_cnt;
  logic [`BEAT_BITS-1:0]      skid_q [2];

  assign wr.cfg_ready = (w_state == W_GET_HDR);
  assign wr.wr_ready  = (w_state == W_WRITE);
  assign hdr_take     = wr.cfg_ready && wr.cfg_valid;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      w_state <= W_IDLE;
      w_idx   <= 1'b0;
    end else begin
      case (w_state)
        W_IDLE:    if (done_read[w_idx]) w_state <= W_GET_HDR; // Bank has been played back
        W_GET_HDR: if (wr.cfg_valid) w_state <= W_WRITE;
        W_WRITE:   if (wr.wr_valid && wr.wr_last) w_state <= W_SWITCH;
        W_SWITCH: begin
          w_state <= W_IDLE;
          w_idx   <= !w_idx;
        end
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      r_state <= R_IDLE;
      r_idx   <= 1'b0;
    end else begin
      case (r_state)
        R_IDLE:   if (done_write[r_idx]) r_state <= R_READ;
        R_READ:   if (rd.rd_done) r_state <= R_SWITCH;
        R_SWITCH: begin
          r_state <= R_IDLE;
          r_idx   <= !r_idx;
        end
        default:  r_state <= R_IDLE;
      endcase
    end
  end

  // Done flags hand each bank between the two FSMs
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      done_write <= 2'b00;
      done_read  <= 2'b11;   // Both banks free after reset
    end else begin
      if (hdr_take) done_read[w_idx] <= 1'b0;
      if (w_state == W_SWITCH) done_write[w_idx] <= 1'b1;
      if (r_state == R_IDLE && done_write[r_idx]) done_write[r_idx] <= 1'b0;
      if (r_state == R_SWITCH) done_read[r_idx] <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) wq_valid <= 1'b0;
    else          wq_valid <= wr.wr_valid && wr.wr_ready;
  end

  always_ff @(posedge aclk) begin
    wq_data <= wr.wr_data;
    if (hdr_take) hdr_reg[w_idx] <= wr.cfg;
  end

  // Issue a read only if the skid still has room when the data lands
  assign pop = rd.rd_valid && rd.rd_ready;
  assign occ = skid_cnt + {1'b0, pend} - {1'b0, pop};
  assign ren = (r_state == R_READ) && (occ <= 2'd1);

  for (genvar i = 0; i < 2; i++) begin : g_bank
    assign bank_clear[i] = hdr_take && (w_idx == i);
    assign bank_wen[i]   = wq_valid && (w_idx == i);
    assign bank_ren[i]   = ren && (r_idx == i);

    weight_bank u_bank (
      .aclk    (aclk),
      .aresetn (aresetn),
      .i_clear (bank_clear[i]),
      .i_wen   (bank_wen[i]),
      .i_wdata (wq_data),
      .i_ren   (bank_ren[i]),
      .i_len   (hdr_reg[i].kern_len),
      .o_rdata (bank_rdata[i])
    );
  end

  // Prefetched beats are dropped when the counter signals done
  always_ff @(posedge aclk) begin
    if (!aresetn || rd.rd_done) begin
      pend     <= 1'b0;
      skid_cnt <= 2'd0;
    end else begin
      pend     <= ren;
      skid_cnt <= occ;
    end
  end

  always_ff @(posedge aclk) begin
    if (pop) skid_q[0] <= skid_q[1];
    if (pend && skid_cnt == {1'b0, pop}) skid_q[0] <= bank_rdata[r_idx];
    if (pend && skid_cnt != {1'b0, pop}) skid_q[1] <= bank_rdata[r_idx];
  end

  assign rd.rd_valid = (skid_cnt != 2'd0);
  assign rd.rd_data  = skid_q[0];
  assign rd.cfg      = hdr_reg[r_idx];

endmodule

//--- rtl/bank/weight_bank.sv
//----------------------------------------------------------
// One weight bank with a linear write pointer and a cyclic
// read pointer that wraps at the kernel length
//----------------------------------------------------------
`timescale 1ns/1ns
`include "rotator_params.svh"

module weight_bank (
  input  logic                             aclk,
  input  logic                             aresetn,
  input  logic                             i_clear,
  input  logic                             i_wen,
  input  logic [`BEAT_BITS-1:0]            i_wdata,
  input  logic                             i_ren,
  input  logic [rotator_pkg::BITS_LEN-1:0] i_len,
  output logic [`BEAT_BITS-1:0]            o_rdata
);

  localparam int AW = rotator_pkg::BITS_ADDR;
  localparam int LW = rotator_pkg::BITS_LEN;

  logic [`BEAT_BITS-1:0] mem [`BANK_DEPTH];
  logic [AW-1:0]         wptr;
  logic [AW-1:0]         rptr;

  always_ff @(posedge aclk) begin
    if (!aresetn || i_clear) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (i_wen) wptr <= wptr + 1'b1;
      if (i_ren) rptr <= (LW'(rptr) == i_len - LW'(1)) ? '0 : rptr + 1'b1; // Kernel pass wrap
    end
  end

  // One cycle read latency
  always_ff @(posedge aclk) begin
    if (i_wen) mem[wptr] <= i_wdata;
    if (i_ren) o_rdata <= mem[rptr];
  end

endmodule

//--- rtl/header_decoder.sv
//----------------------------------------------------------
// Splits each input packet into its header and weight beats
// Header goes out with the kernel length per pass
//----------------------------------------------------------
`timescale 1ns/1ns
`include "rotator_params.svh"

module header_decoder (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  i_s_valid,
  output logic                  o_s_ready,
  input  logic [`BEAT_BITS-1:0] i_s_data,
  input  logic                  i_s_last,
  bank_write_if.decoder         wr
);

  localparam int LW = rotator_pkg::BITS_LEN;

  typedef enum logic {D_HEADER, D_WEIGHTS} dec_state_t;

  dec_state_t               state;
  rotator_pkg::rot_config_t hdr;
  logic [LW-1:0]            kw_len;
  logic [LW-1:0]            ci_len;

  assign hdr    = i_s_data[$bits(rotator_pkg::rot_config_t)-1:0];
  assign kw_len = LW'({hdr.kw2, 1'b1});          // 2*kw2+1
  assign ci_len = LW'(hdr.cin_1) + LW'(1);

  assign wr.cfg = '{kern_len: kw_len * ci_len, cfg: hdr};

  // Header only offered while the controller can take it
  assign wr.cfg_valid = (state == D_HEADER) && i_s_valid && wr.cfg_ready;

  assign wr.wr_valid = (state == D_WEIGHTS) && i_s_valid;
  assign wr.wr_data  = i_s_data;
  assign wr.wr_last  = i_s_last;

  assign o_s_ready = (state == D_HEADER) ? wr.cfg_ready : wr.wr_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= D_HEADER;
    end else if (state == D_HEADER && wr.cfg_valid) begin
      state <= D_WEIGHTS;
    end else if (state == D_WEIGHTS && wr.wr_valid && wr.wr_ready && wr.wr_last) begin
      state <= D_HEADER; // Next beat is a new header
    end
  end

endmodule

//--- common/bank_read_if.sv
//----------------------------------------------------------
// Bank controller to rotation counter link
// cfg belongs to the bank that is being read
//----------------------------------------------------------
`timescale 1ns/1ns
`include "rotator_params.svh"

interface bank_read_if;

  logic                       rd_valid;
  logic                       rd_ready;
  logic [`BEAT_BITS-1:0]      rd_data;
  rotator_pkg::rot_bank_cfg_t cfg;
  logic                       rd_done; // Pulse on the final beat, frees the bank

  modport ctrl    (output rd_valid, rd_data, cfg,
                   input  rd_ready, rd_done);

  modport counter (input  rd_valid, rd_data, cfg,
                   output rd_ready, rd_done);

endinterface

//--- common/bank_write_if.sv
//----------------------------------------------------------
// Decoder to bank controller link
// Carries the decoded header and the weight beats
//----------------------------------------------------------
`timescale 1ns/1ns
`include "rotator_params.svh"

interface bank_write_if;

  logic                       wr_valid;
  logic                       wr_ready;
  logic [`BEAT_BITS-1:0]      wr_data;
  logic                       wr_last;   // Final weight of the packet
  logic                       cfg_valid; // Single cycle, only while cfg_ready
  logic                       cfg_ready;
  rotator_pkg::rot_bank_cfg_t cfg;

  modport decoder (output wr_valid, wr_data, wr_last, cfg_valid, cfg,
                   input  wr_ready, cfg_ready);

  modport ctrl    (input  wr_valid, wr_data, wr_last, cfg_valid, cfg,
                   output wr_ready, cfg_ready);

endinterface

//--- common/rotator_pkg.sv
//----------------------------------------------------------
// Header, bank config and tuser types of the weight rotator
// Referenced by scoped name from every block
//----------------------------------------------------------
`include "rotator_params.svh"

package rotator_pkg;

  localparam int BITS_KW2  = $clog2((`KW_MAX + 1) / 2);
  localparam int BITS_KW   = BITS_KW2 + 1;          // Counts up to 2*kw2
  localparam int BITS_CI   = $clog2(`CI_MAX);
  localparam int BITS_XW   = $clog2(`XW_MAX);
  localparam int BITS_BLK  = $clog2(`XH_BLOCKS_MAX);
  localparam int BITS_XN   = $clog2(`XN_MAX);
  localparam int BITS_ADDR = $clog2(`BANK_DEPTH);
  localparam int BITS_LEN  = $clog2(`BANK_DEPTH + 1); // Kernel words per pass

  // Low bits of the first beat, kw2 in the LSBs
  typedef struct packed {
    logic [BITS_XN-1:0]  xn_1;
    logic [BITS_BLK-1:0] blocks_1;
    logic [BITS_XW-1:0]  cols_1;
    logic [BITS_CI-1:0]  cin_1;
    logic [BITS_KW2-1:0] kw2;
  } rot_config_t;

  typedef struct packed {
    logic [BITS_LEN-1:0] kern_len;
    rot_config_t         cfg;
  } rot_bank_cfg_t;

  typedef struct packed {
    logic                is_config;
    logic [BITS_KW2-1:0] kw2;
    logic                is_w_first_clk; // First beat of a column
    logic                is_cin_last;    // Last beat of a kernel pass
    logic                is_w_last;      // Last column
  } rot_user_t;

endpackage

//--- common/rotator_params.svh
//----------------------------------------------------------
// Size macros for the weight rotator
// Include wherever a beat width or a bank size is needed
//----------------------------------------------------------
`ifndef ROTATOR_PARAMS_SVH
`define ROTATOR_PARAMS_SVH

`define COLS            4    // Weight words per beat
`define K_BITS          8    // Bits per weight
`define KW_MAX          7    // Largest odd kernel width
`define CI_MAX          8
`define XW_MAX          16   // Columns
`define XH_BLOCKS_MAX   4    // Row blocks
`define XN_MAX          4    // Images

// One bank holds a full kernel pass
`define BANK_DEPTH      64
`define BEAT_BITS       (`COLS * `K_BITS)

`endif
